// File: Bender.yml
package:
  name: rename_unit

sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - free_list.sv
      - mapping_table.sv
      - rat.sv
      - rename_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_rename_unit.sv

// File: free_list.sv
/*
 * Circular FIFO of free physical registers
 * Pops at the head on allocation, pushes at the tail on retire,
 * head can be rewound to a checkpointed position
 */
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module free_list
  import rename_pkg::*;
(
  input  wire                                clock,
  input  wire                                reset,
  input  wire alloc_cnt_t                    alloc_count,
  output prf_index_t [`RENAME_WIDTH-1:0]     alloc_prd,
  output logic [`FL_PTR_W:0]                 free_count,
  input  wire                                retire_valid,
  input  wire prf_index_t                    retire_prd,
  input  wire                                cp_save,
  output fl_ptr_t                            head_snapshot,
  input  wire                                fl_restore,
  input  wire fl_ptr_t                       restore_head
);

  localparam int FL_DEPTH = `PRF_SIZE - `ARF_SIZE;
  localparam int IDX_W    = `FL_PTR_W;

  prf_index_t fl_mem [FL_DEPTH];
  fl_ptr_t    head;
  fl_ptr_t    tail;

  // Wrap bit makes the difference 0..FL_DEPTH
  assign free_count    = tail - head;
  assign head_snapshot = head;

  // Entries at the head, offered for this cycle's allocation
  always_comb begin
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      alloc_prd[s] = fl_mem[IDX_W'(head + fl_ptr_t'(s))];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= fl_ptr_t'(FL_DEPTH);
      // Registers above the identity map start out free
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= prf_index_t'(`ARF_SIZE + i);
      end
    end else begin
      if (fl_restore) begin
        head <= restore_head;
      end else begin
        head <= head + fl_ptr_t'(alloc_count);
      end
      if (retire_valid) begin
        fl_mem[tail[IDX_W-1:0]] <= retire_prd;
        tail <= tail + 1'b1;
      end
    end
  end

  // Controller only pops what it has seen as free
  a_alloc_within_free: assert property (@(posedge clock) disable iff (reset)
    fl_ptr_t'(alloc_count) <= free_count);

  // Retire of a register that was never handed out would overflow the ring
  a_no_retire_when_full: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> (free_count != FL_DEPTH));

  // A checkpoint taken during a rewind would store a stale head
  a_no_save_on_restore: assert property (@(posedge clock) disable iff (reset)
    !(cp_save && fl_restore));

endmodule

`default_nettype wire

// File: list.f
+incdir+.
rename_pkg.sv
free_list.sv
mapping_table.sv
rat.sv
rename_unit.sv
tb_clock_gen.sv
tb_rename_unit.sv

// File: mapping_table.sv
/*
 * Speculative register map with group lookup and in-group bypass
 * Per-tag copies of the map for branch checkpoints
 */
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module mapping_table
  import rename_pkg::*;
(
  input  wire                                clock,
  input  wire                                reset,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] rs1,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] rs2,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] rd,
  input  wire [`RENAME_WIDTH-1:0]            rd_write,
  input  wire prf_index_t [`RENAME_WIDTH-1:0] new_prd,
  input  wire                                commit_group,
  output prf_index_t [`RENAME_WIDTH-1:0]     prs1,
  output prf_index_t [`RENAME_WIDTH-1:0]     prs2,
  output prf_index_t [`RENAME_WIDTH-1:0]     prev_prd,
  input  wire                                cp_save,
  input  wire slot_idx_t                     cp_slot,
  input  wire cp_tag_t                       cp_tag,
  input  wire                                cp_restore,
  input  wire cp_tag_t                       restore_tag
);

  // Live map
  prf_index_t map_q [`ARF_SIZE];

  // Saved maps, one per checkpoint tag
  prf_index_t cp_map [`CP_DEPTH][`ARF_SIZE];

  // Map as it stands after each slot of the current group
  prf_index_t map_step [`RENAME_WIDTH][`ARF_SIZE];

  // Walk the group in order: every slot reads the map left by the slots before it,
  // which gives the in-group bypass without separate compare logic
  always_comb begin
    prf_index_t map_tmp [`ARF_SIZE];

    map_tmp = map_q;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      // x0 is hardwired to physical register 0
      prs1[s]     = (rs1[s] == '0) ? '0 : map_tmp[rs1[s]];
      prs2[s]     = (rs2[s] == '0) ? '0 : map_tmp[rs2[s]];
      prev_prd[s] = map_tmp[rd[s]];
      if (rd_write[s]) begin
        map_tmp[rd[s]] = new_prd[s];
      end
      map_step[s] = map_tmp;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity map
      for (int a = 0; a < `ARF_SIZE; a++) begin
        map_q[a] <= prf_index_t'(a);
      end
    end else if (cp_restore) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        map_q[a] <= cp_map[restore_tag][a];
      end
    end else if (commit_group) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        map_q[a] <= map_step[`RENAME_WIDTH-1][a];
      end
    end
  end

  // Snapshot stops at the branch, younger slots in the group are not included
  always_ff @(posedge clock) begin
    if (cp_save) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        cp_map[cp_tag][a] <= map_step[cp_slot][a];
      end
    end
  end

endmodule

`default_nettype wire

// File: rat.sv
/*
 * Rename controller: four-phase handshake, free-list and checkpoint checks,
 * checkpoint ring with saved free-list heads, registered results
 */
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rat
  import rename_pkg::*;
(
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 rename_req,
  output logic                                rename_ack,
  input  wire [`RENAME_WIDTH-1:0]             in_valid,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rs1,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rs2,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rd,
  input  wire [`RENAME_WIDTH-1:0]             in_rd_write,
  input  wire [`RENAME_WIDTH-1:0]             in_branch,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prs1,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prs2,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prd,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prev_prd,
  output cp_tag_t                             out_tag,
  input  wire                                 resolve_valid,
  input  wire cp_tag_t                        resolve_tag,
  input  wire                                 resolve_mispredict,
  output alloc_cnt_t                          alloc_count,
  input  wire prf_index_t [`RENAME_WIDTH-1:0] alloc_prd,
  input  wire [`FL_PTR_W:0]                   free_count,
  output logic                                cp_save,
  input  wire fl_ptr_t                        head_snapshot,
  output logic                                fl_restore,
  output fl_ptr_t                             restore_head,
  input  wire                                 retire_valid
);

  rename_state_t                   state;
  rename_state_t                   state_next;

  logic [`RENAME_WIDTH-1:0]        wr_en;
  prf_index_t [`RENAME_WIDTH-1:0]  new_prd;
  prf_index_t [`RENAME_WIDTH-1:0]  map_prs1;
  prf_index_t [`RENAME_WIDTH-1:0]  map_prs2;
  prf_index_t [`RENAME_WIDTH-1:0]  map_prev;
  alloc_cnt_t                      need;
  alloc_cnt_t                      need_to_branch;
  logic                            has_branch;
  slot_idx_t                       br_slot;
  logic                            commit;
  logic                            cp_restore;

  // Checkpoint ring
  cp_tag_t                         cp_head;
  cp_tag_t                         cp_head_next;
  logic [`CP_TAG_W:0]              cp_count;
  logic [`CP_TAG_W:0]              cp_count_next;
  cp_tag_t                         new_tag;
  cp_tag_t                         resolve_offset;
  logic                            tag_live;
  fl_ptr_t                         cp_fl_head [`CP_DEPTH];

  // Group decode; writing slots take free-list entries in slot order
  always_comb begin
    need           = '0;
    need_to_branch = '0;
    has_branch     = 1'b0;
    br_slot        = '0;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      wr_en[s]   = in_valid[s] && in_rd_write[s] && (in_rd[s] != '0);
      new_prd[s] = wr_en[s] ? alloc_prd[slot_idx_t'(need)] : '0;
      need       = need + alloc_cnt_t'(wr_en[s]);
      if (in_valid[s] && in_branch[s]) begin
        has_branch     = 1'b1;
        br_slot        = slot_idx_t'(s);
        need_to_branch = need;
      end
    end
  end

  assign cp_restore = resolve_valid && resolve_mispredict;
  assign commit     = (state == CHECK) && !cp_restore && (free_count >= need) &&
                      !(has_branch && (cp_count >= `CP_DEPTH));

  assign alloc_count  = commit ? need : '0;
  assign cp_save      = commit && has_branch;
  assign fl_restore   = cp_restore;
  assign restore_head = cp_fl_head[resolve_tag];

  assign new_tag        = cp_head + cp_tag_t'(cp_count);
  assign resolve_offset = resolve_tag - cp_head;
  assign tag_live       = {1'b0, resolve_offset} < cp_count;

  // Correct resolve frees the oldest entry, a mispredict keeps entries up to the tag
  always_comb begin
    cp_head_next  = cp_head;
    cp_count_next = cp_count;
    if (resolve_valid) begin
      if (resolve_mispredict) begin
        cp_count_next = {1'b0, resolve_offset} + 1'b1;
      end else begin
        cp_head_next  = cp_head + 1'b1;
        cp_count_next = cp_count - 1'b1;
      end
    end
    if (cp_save) begin
      cp_count_next = cp_count_next + 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      IDLE:    if (rename_req) state_next = CHECK;
      CHECK:   if (commit) state_next = ACK;
      ACK:     state_next = DRAIN;
      DRAIN:   if (!rename_req) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  assign rename_ack = (state == ACK) || (state == DRAIN);

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      cp_head  <= '0;
      cp_count <= '0;
    end else begin
      state    <= state_next;
      cp_head  <= cp_head_next;
      cp_count <= cp_count_next;
    end
  end

  // Results held from the commit edge through ACK and DRAIN
  always_ff @(posedge clock) begin
    if (commit) begin
      out_prs1 <= map_prs1;
      out_prs2 <= map_prs2;
      out_prd  <= new_prd;
      out_tag  <= new_tag;
      for (int s = 0; s < `RENAME_WIDTH; s++) begin
        out_prev_prd[s] <= wr_en[s] ? map_prev[s] : '0;
      end
    end
    // Head past the branch's own allocations
    if (cp_save) begin
      cp_fl_head[new_tag] <= head_snapshot + fl_ptr_t'(need_to_branch);
    end
  end

  mapping_table u_mapping_table (
    .clock        (clock),
    .reset        (reset),
    .rs1          (in_rs1),
    .rs2          (in_rs2),
    .rd           (in_rd),
    .rd_write     (wr_en),
    .new_prd      (new_prd),
    .commit_group (commit),
    .prs1         (map_prs1),
    .prs2         (map_prs2),
    .prev_prd     (map_prev),
    .cp_save      (cp_save),
    .cp_slot      (br_slot),
    .cp_tag       (new_tag),
    .cp_restore   (cp_restore),
    .restore_tag  (resolve_tag)
  );

  // Sender holds the group steady for the whole request
  a_stable_group: assert property (@(posedge clock) disable iff (reset)
    rename_req ##1 rename_req |->
      $stable({in_valid, in_rs1, in_rs2, in_rd, in_rd_write, in_branch}));

  // Retire and resolve never overlap an acknowledged group
  a_strobe_window: assert property (@(posedge clock) disable iff (reset)
    (resolve_valid || retire_valid) |-> !rename_ack);

  a_resolve_live: assert property (@(posedge clock) disable iff (reset)
    resolve_valid |-> tag_live);

endmodule

`default_nettype wire

// File: rename_cfg.svh
/*
 * Size parameters for the integer rename stage
 */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Micro-ops per rename group
`define RENAME_WIDTH 2

// Architectural and physical integer registers
`define ARF_SIZE 32
`define PRF_SIZE 64

// Index widths for the two register spaces
`define ARF_INDEX_W 5
`define PRF_INDEX_W 6

// Free list holds PRF_SIZE - ARF_SIZE entries, pointer adds a wrap bit
`define FL_PTR_W 5

// Branch checkpoints
`define CP_DEPTH 4
`define CP_TAG_W 2

`endif

// File: rename_pkg.sv
/*
 * Shared types for the rename stage
 * Register indices, free-list pointer, checkpoint tag, controller states
 */
`default_nettype none
`include "rename_cfg.svh"

package rename_pkg;

  // Architectural register index, x0 to x31
  typedef logic [`ARF_INDEX_W-1:0] arf_index_t;

  // Physical register index
  typedef logic [`PRF_INDEX_W-1:0] prf_index_t;

  // Free-list pointer, MSB is the wrap bit
  typedef logic [`FL_PTR_W:0] fl_ptr_t;

  // Checkpoint ring index
  typedef logic [`CP_TAG_W-1:0] cp_tag_t;

  // Position of a micro-op inside its group
  typedef logic [$clog2(`RENAME_WIDTH)-1:0] slot_idx_t;

  // Registers taken from the free list in one cycle, 0 to RENAME_WIDTH
  typedef logic [$clog2(`RENAME_WIDTH+1)-1:0] alloc_cnt_t;

  // Rename controller
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ACK,
    DRAIN
  } rename_state_t;

endpackage

`default_nettype wire

// File: rename_unit.sv
/*
 * Integer rename stage top: controller and free list
 */
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rename_unit
  import rename_pkg::*;
(
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 rename_req,
  output logic                                rename_ack,
  input  wire [`RENAME_WIDTH-1:0]             in_valid,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rs1,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rs2,
  input  wire arf_index_t [`RENAME_WIDTH-1:0] in_rd,
  input  wire [`RENAME_WIDTH-1:0]             in_rd_write,
  input  wire [`RENAME_WIDTH-1:0]             in_branch,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prs1,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prs2,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prd,
  output prf_index_t [`RENAME_WIDTH-1:0]      out_prev_prd,
  output cp_tag_t                             out_tag,
  input  wire                                 retire_valid,
  input  wire prf_index_t                     retire_prd,
  input  wire                                 resolve_valid,
  input  wire cp_tag_t                        resolve_tag,
  input  wire                                 resolve_mispredict
);

  // Controller to free list
  alloc_cnt_t                      alloc_count;
  prf_index_t [`RENAME_WIDTH-1:0]  alloc_prd;
  logic [`FL_PTR_W:0]              free_count;
  logic                            cp_save;
  fl_ptr_t                         head_snapshot;
  logic                            fl_restore;
  fl_ptr_t                         restore_head;

  rat u_rat (.*);

  free_list u_free_list (.*);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock, 10 ns period, and synchronous reset held for 2 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_rename_unit.sv
/*
 * Testbench for the rename stage: table of groups and strobes applied in a loop,
 * reference map, free-register queue and checkpoint copies for expected results
 */
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module tb_rename_unit
  import rename_pkg::*;
();

  typedef enum logic [2:0] {K_REN, K_STALL, K_ACK, K_RETIRE, K_RESOLVE} row_kind_t;

  // A group for the rename kinds, a strobe for retire and resolve
  typedef struct packed {
    row_kind_t                      kind;
    logic [`RENAME_WIDTH-1:0]       valid;
    logic [`RENAME_WIDTH-1:0]       wr;
    logic [`RENAME_WIDTH-1:0]       br;
    arf_index_t [`RENAME_WIDTH-1:0] rs1;
    arf_index_t [`RENAME_WIDTH-1:0] rs2;
    arf_index_t [`RENAME_WIDTH-1:0] rd;
    cp_tag_t                        tag;
    logic                           mispredict;
    prf_index_t                     prd;
  } row_t;

  logic                           clock;
  logic                           reset;
  logic                           rename_req;
  logic                           rename_ack;
  logic [`RENAME_WIDTH-1:0]       in_valid;
  arf_index_t [`RENAME_WIDTH-1:0] in_rs1;
  arf_index_t [`RENAME_WIDTH-1:0] in_rs2;
  arf_index_t [`RENAME_WIDTH-1:0] in_rd;
  logic [`RENAME_WIDTH-1:0]       in_rd_write;
  logic [`RENAME_WIDTH-1:0]       in_branch;
  prf_index_t [`RENAME_WIDTH-1:0] out_prs1;
  prf_index_t [`RENAME_WIDTH-1:0] out_prs2;
  prf_index_t [`RENAME_WIDTH-1:0] out_prd;
  prf_index_t [`RENAME_WIDTH-1:0] out_prev_prd;
  cp_tag_t                        out_tag;
  logic                           retire_valid;
  prf_index_t                     retire_prd;
  logic                           resolve_valid;
  cp_tag_t                        resolve_tag;
  logic                           resolve_mispredict;

  // Reference model
  row_t       rows [$];
  row_t       pending;
  prf_index_t model_map [`ARF_SIZE];
  prf_index_t saved_map [`CP_DEPTH][`ARF_SIZE];
  int         saved_len [`CP_DEPTH];
  prf_index_t free_q [$];
  prf_index_t alloc_log [$];
  int         error_count = 0;
  int         failed_rows = 0;
  int         cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  rename_unit u_dut (.*);

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > rows.size() * 40 + 200) begin
      $display("timeout: the run did not end within %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic flag_mismatch(input string name, input int slot, input logic [7:0] expected,
                               input logic [7:0] actual);
    $display("mismatch %s[%0d]: expected %h, got %h", name, slot, expected, actual);
    error_count++;
  endtask

  task automatic note_failure(input string msg);
    $display("error: %s", msg);
    error_count++;
  endtask

  task automatic push_group(input row_kind_t kind, input logic [1:0] valid,
                            input logic [1:0] wr, input logic [1:0] br,
                            input int rs1_0, input int rs2_0, input int rd_0,
                            input int rs1_1, input int rs2_1, input int rd_1, input int tag);
    row_t r;
    r = '{kind, valid, wr, br, {arf_index_t'(rs1_1), arf_index_t'(rs1_0)},
          {arf_index_t'(rs2_1), arf_index_t'(rs2_0)},
          {arf_index_t'(rd_1), arf_index_t'(rd_0)}, cp_tag_t'(tag), 1'b0, '0};
    rows.push_back(r);
  endtask

  task automatic append_strobe(input row_kind_t kind, input int tag, input logic mispredict,
                               input int prd);
    row_t r;
    r = '{kind, '0, '0, '0, '0, '0, '0, cp_tag_t'(tag), mispredict, prf_index_t'(prd)};
    rows.push_back(r);
  endtask

  task automatic start_group(input row_t r);
    pending = r;
    @(posedge clock);
    in_valid    <= r.valid;
    in_rs1      <= r.rs1;
    in_rs2      <= r.rs2;
    in_rd       <= r.rd;
    in_rd_write <= r.wr;
    in_branch   <= r.br;
    rename_req  <= 1'b1;
  endtask

  task automatic expect_stall();
    repeat (20) begin
      @(negedge clock);
      if (rename_ack) note_failure("ack arrived while the group should be stalled");
    end
  endtask

  task automatic finish_group(input row_t r);
    prf_index_t  exp_prs1 [`RENAME_WIDTH];
    prf_index_t  exp_prs2 [`RENAME_WIDTH];
    prf_index_t  exp_prd [`RENAME_WIDTH];
    prf_index_t  exp_prev [`RENAME_WIDTH];
    logic [49:0] held;
    int          ack_cycles;

    @(negedge clock);
    while (!rename_ack) @(negedge clock);
    // Slots in order, each one sees the writes of the slots before it
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      exp_prs1[s] = (r.rs1[s] == '0) ? '0 : model_map[r.rs1[s]];
      exp_prs2[s] = (r.rs2[s] == '0) ? '0 : model_map[r.rs2[s]];
      exp_prd[s]  = '0;
      exp_prev[s] = '0;
      if (r.valid[s] && r.wr[s] && (r.rd[s] != '0) && (free_q.size() > 0)) begin
        exp_prev[s] = model_map[r.rd[s]];
        exp_prd[s]  = free_q.pop_front();
        alloc_log.push_back(exp_prd[s]);
        model_map[r.rd[s]] = exp_prd[s];
      end
      if (r.valid[s] && r.br[s]) begin
        for (int a = 0; a < `ARF_SIZE; a++) saved_map[r.tag][a] = model_map[a];
        saved_len[r.tag] = alloc_log.size();
      end
    end
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      if (r.valid[s]) begin
        if (out_prs1[s] !== exp_prs1[s]) flag_mismatch("out_prs1", s, exp_prs1[s], out_prs1[s]);
        if (out_prs2[s] !== exp_prs2[s]) flag_mismatch("out_prs2", s, exp_prs2[s], out_prs2[s]);
        if (out_prd[s] !== exp_prd[s]) flag_mismatch("out_prd", s, exp_prd[s], out_prd[s]);
        if (out_prev_prd[s] !== exp_prev[s])
          flag_mismatch("out_prev_prd", s, exp_prev[s], out_prev_prd[s]);
      end
    end
    if ((r.br != '0) && (out_tag !== r.tag)) flag_mismatch("out_tag", 0, r.tag, out_tag);
    held = {out_prs1, out_prs2, out_prd, out_prev_prd, out_tag};
    @(posedge clock);
    rename_req <= 1'b0;
    ack_cycles = 0;
    @(negedge clock);
    while (rename_ack) begin
      if ({out_prs1, out_prs2, out_prd, out_prev_prd, out_tag} !== held)
        note_failure("results changed while ack was high");
      ack_cycles++;
      @(negedge clock);
    end
    if (ack_cycles > 2) note_failure("ack stayed high more than 2 cycles after req fell");
  endtask

  task automatic apply_strobe(input row_t r);
    @(posedge clock);
    if (r.kind == K_RETIRE) begin
      retire_valid <= 1'b1;
      retire_prd   <= r.prd;
      free_q.push_back(r.prd);
    end else begin
      resolve_valid      <= 1'b1;
      resolve_tag        <= r.tag;
      resolve_mispredict <= r.mispredict;
      // Wrong-path registers go back to the front of the queue in their old order
      if (r.mispredict) begin
        for (int a = 0; a < `ARF_SIZE; a++) model_map[a] = saved_map[r.tag][a];
        while (alloc_log.size() > saved_len[r.tag]) free_q.push_front(alloc_log.pop_back());
      end
    end
    @(posedge clock);
    retire_valid  <= 1'b0;
    resolve_valid <= 1'b0;
  endtask

  initial begin
    row_t r;
    int   errors_before;
    int   fill_rd;

    rename_req         <= 1'b0;
    in_valid           <= '0;
    in_rs1             <= '0;
    in_rs2             <= '0;
    in_rd              <= '0;
    in_rd_write        <= '0;
    in_branch          <= '0;
    retire_valid       <= 1'b0;
    retire_prd         <= '0;
    resolve_valid      <= 1'b0;
    resolve_tag        <= '0;
    resolve_mispredict <= 1'b0;
    for (int a = 0; a < `ARF_SIZE; a++) model_map[a] = prf_index_t'(a);
    for (int p = `ARF_SIZE; p < `PRF_SIZE; p++) free_q.push_back(prf_index_t'(p));

    push_group(K_REN, 2'b11, 2'b11, 2'b00, 1, 2, 3, 4, 5, 6, 0);
    // Slot 1 reads slot 0's rd, x0 as source and as destination
    push_group(K_REN, 2'b11, 2'b11, 2'b00, 3, 0, 7, 7, 3, 0, 0);
    for (int i = 0; i < 14; i++) begin
      fill_rd = 8 + (2 * i) % 24;
      push_group(K_REN, 2'b11, 2'b11, 2'b00, fill_rd, fill_rd + 1, fill_rd,
                 fill_rd, fill_rd + 1, fill_rd + 1, 0);
    end
    push_group(K_REN, 2'b11, 2'b01, 2'b00, 20, 21, 20, 22, 23, 21, 0);
    // Free list is empty here
    push_group(K_STALL, 2'b11, 2'b11, 2'b00, 1, 3, 1, 1, 6, 2, 0);
    append_strobe(K_RETIRE, 0, 1'b0, 3);
    append_strobe(K_RETIRE, 0, 1'b0, 6);
    append_strobe(K_ACK, 0, 1'b0, 0);
    for (int p = 7; p <= 10; p++) append_strobe(K_RETIRE, 0, 1'b0, p);
    // Branch groups fill all four checkpoints
    push_group(K_REN, 2'b11, 2'b10, 2'b01, 1, 2, 0, 5, 0, 5, 0);
    push_group(K_REN, 2'b11, 2'b01, 2'b10, 5, 0, 5, 5, 3, 0, 1);
    push_group(K_REN, 2'b01, 2'b00, 2'b01, 1, 2, 0, 0, 0, 0, 2);
    push_group(K_REN, 2'b01, 2'b00, 2'b01, 3, 4, 0, 0, 0, 0, 3);
    push_group(K_STALL, 2'b11, 2'b10, 2'b01, 11, 5, 0, 11, 5, 11, 0);
    append_strobe(K_RESOLVE, 0, 1'b0, 0);
    append_strobe(K_ACK, 0, 1'b0, 0);
    append_strobe(K_RESOLVE, 1, 1'b1, 0);
    push_group(K_REN, 2'b11, 2'b11, 2'b00, 5, 11, 11, 11, 5, 12, 0);
    append_strobe(K_RESOLVE, 1, 1'b0, 0);

    @(negedge clock);
    while (reset) @(negedge clock);
    if (rename_ack) note_failure("ack high after reset");

    for (int i = 0; i < rows.size(); i++) begin
      errors_before = error_count;
      r = rows[i];
      case (r.kind)
        K_REN: begin
          start_group(r);
          finish_group(r);
        end
        K_STALL: begin
          start_group(r);
          expect_stall();
        end
        K_ACK: finish_group(pending);
        default: apply_strobe(r);
      endcase
      if (error_count != errors_before) failed_rows++;
      $display("row %0d %s %s", i, r.kind.name(), (error_count == errors_before) ? "ok" : "failed");
    end

    $display("rows %0d, failed rows %0d, errors %0d", rows.size(), failed_rows, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
